//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exu_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/axil_ctrl_fsm.sv
rtl/exu_regs.sv
rtl/retire_counter.sv
rtl/exu_top.sv
tb/exu_checker.sv
tb/tb_exu_top.sv

//--- rtl/axil_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module axil_ctrl_fsm (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       awvalid_i,
  input  logic                       wvalid_i,
  input  logic                       bready_i,
  input  logic                       arvalid_i,
  input  logic                       rready_i,
  input  logic [exu_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                       cmd_ok_i,
  output logic                       awready_o,
  output logic                       wready_o,
  output logic                       bvalid_o,
  output logic [1:0]                 bresp_o,
  output logic                       arready_o,
  output logic                       rvalid_o,
  output logic                       wr_en_o,
  output logic                       rd_en_o,
  output logic                       exec_o
);
  import exu_pkg::*;

  axil_state_e state_q;
  logic        idle;
  logic        wr_pending;

  assign idle       = (state_q == ST_IDLE);
  assign wr_pending = awvalid_i && wvalid_i;

  // address and data are taken together, writes win over reads
  assign awready_o = idle && wr_pending;
  assign wready_o  = idle && wr_pending;
  assign arready_o = idle && !wr_pending;

  assign wr_en_o  = awready_o;
  assign rd_en_o  = arready_o && arvalid_i;
  assign exec_o   = (state_q == ST_EXEC);
  assign bvalid_o = (state_q == ST_WRESP);
  assign rvalid_o = (state_q == ST_RDATA);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      bresp_o <= RESP_OKAY;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_en_o) begin
            bresp_o <= RESP_OKAY;
            state_q <= (awaddr_i == REG_CMD) ? ST_EXEC : ST_WRESP;
          end else if (rd_en_o) begin
            state_q <= ST_RDATA;
          end
        end
        // one cycle for the result registers to load
        ST_EXEC: begin
          bresp_o <= cmd_ok_i ? RESP_OKAY : RESP_SLVERR;
          state_q <= ST_WRESP;
        end
        ST_WRESP: begin
          if (bready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          if (rready_i) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  exu_pkg::exu_op_e              op_i,
  input  logic                          wop_i,
  input  exu_pkg::ls_size_e             size_i,
  input  logic                          usign_i,
  input  logic [XLEN-1:0]               op1_i,
  input  logic [XLEN-1:0]               op2_i,
  input  logic [XLEN-1:0]               pc_i,
  input  logic [XLEN-1:0]               imm_i,
  output logic [XLEN-1:0]               alu_res_o,
  output logic                          jump_flag_o,
  output logic [XLEN-1:0]               jump_addr_o,
  output logic [exu_pkg::LS_INFO_W-1:0] ls_info_o,
  output logic [XLEN-1:0]               store_data_o
);
  import exu_pkg::*;

  localparam int SH_W = $clog2(XLEN);

  logic            op_ls;
  logic            op_sub_need;
  logic            op_addr_imm;
  logic [XLEN-1:0] adder_b;
  logic            adder_cin;
  logic            adder_cout;
  logic [XLEN-1:0] adder_sum;
  logic [XLEN-1:0] word_res;
  logic [XLEN-1:0] link_res;
  logic [SH_W-1:0] shamt;
  logic            slt_cmp;
  logic            sltu_cmp;
  logic            eq_cmp;

  assign op_ls = (op_i == OP_LOAD) || (op_i == OP_STORE);

  // compares and branches run through the subtractor
  assign op_sub_need = op_i inside {OP_SUB, OP_SLT, OP_SLTU, OP_BEQ, OP_BNE,
                                    OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

  // address forms add the immediate to op1
  assign op_addr_imm = op_ls || (op_i == OP_JALR);

  assign adder_b   = op_sub_need ? ~op2_i : (op_addr_imm ? imm_i : op2_i);
  assign adder_cin = op_sub_need;

  assign {adder_cout, adder_sum} = op1_i + adder_b + XLEN'(adder_cin);

  // signed less-than from sign bits and the difference
  assign slt_cmp = (op1_i[XLEN-1] & ~op2_i[XLEN-1]) |
                   (~(op1_i[XLEN-1] ^ op2_i[XLEN-1]) & adder_sum[XLEN-1]);
  // no carry out of a - b means a < b unsigned
  assign sltu_cmp = ~adder_cout;
  assign eq_cmp   = ~|adder_sum;

  assign word_res = {{(XLEN-32){adder_sum[31]}}, adder_sum[31:0]};
  assign link_res = pc_i + XLEN'(4);
  assign shamt    = op2_i[SH_W-1:0];

  always_comb begin
    case (op_i)
      OP_ADD, OP_SUB:   alu_res_o = wop_i ? word_res : adder_sum;
      OP_SLL:           alu_res_o = op1_i << shamt;
      OP_SRL:           alu_res_o = op1_i >> shamt;
      OP_SRA:           alu_res_o = $signed(op1_i) >>> shamt;
      OP_SLT:           alu_res_o = XLEN'(slt_cmp);
      OP_SLTU:          alu_res_o = XLEN'(sltu_cmp);
      OP_XOR:           alu_res_o = op1_i ^ op2_i;
      OP_OR:            alu_res_o = op1_i | op2_i;
      OP_AND:           alu_res_o = op1_i & op2_i;
      OP_LUI:           alu_res_o = op2_i;
      OP_JAL, OP_JALR:  alu_res_o = link_res;
      OP_LOAD, OP_STORE: alu_res_o = adder_sum;
      default:          alu_res_o = '0;
    endcase
  end

  always_comb begin
    case (op_i)
      OP_BEQ:          jump_flag_o = eq_cmp;
      OP_BNE:          jump_flag_o = ~eq_cmp;
      OP_BLT:          jump_flag_o = slt_cmp;
      OP_BGE:          jump_flag_o = ~slt_cmp;
      OP_BLTU:         jump_flag_o = sltu_cmp;
      OP_BGEU:         jump_flag_o = ~sltu_cmp;
      OP_JAL, OP_JALR: jump_flag_o = 1'b1;
      default:         jump_flag_o = 1'b0;
    endcase
  end

  // jalr target comes from the shared adder, lsb forced low
  assign jump_addr_o = (op_i == OP_JALR) ? {adder_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;

  // {double, word, half, byte, unsigned, store, load}
  assign ls_info_o = {op_ls && (size_i == LS_DOUBLE),
                      op_ls && (size_i == LS_WORD),
                      op_ls && (size_i == LS_HALF),
                      op_ls && (size_i == LS_BYTE),
                      op_ls && usign_i,
                      op_i == OP_STORE,
                      op_i == OP_LOAD};

  assign store_data_o = (op_i == OP_STORE) ? op2_i : '0;

endmodule

`default_nettype wire

//--- rtl/exu_pkg.sv
`default_nettype none

package exu_pkg;

  localparam int XLEN   = 64;
  localparam int ADDR_W = 7;
  localparam int CNT_W  = 32;

  // operation codes, 22..31 are undefined
  typedef enum logic [4:0] {
    OP_ADD    = 5'd0,
    OP_SUB    = 5'd1,
    OP_SLL    = 5'd2,
    OP_SRL    = 5'd3,
    OP_SRA    = 5'd4,
    OP_SLT    = 5'd5,
    OP_SLTU   = 5'd6,
    OP_XOR    = 5'd7,
    OP_OR     = 5'd8,
    OP_AND    = 5'd9,
    OP_LUI    = 5'd10,
    OP_JAL    = 5'd11,
    OP_JALR   = 5'd12,
    OP_BEQ    = 5'd13,
    OP_BNE    = 5'd14,
    OP_BLT    = 5'd15,
    OP_BGE    = 5'd16,
    OP_BLTU   = 5'd17,
    OP_BGEU   = 5'd18,
    OP_LOAD   = 5'd19,
    OP_STORE  = 5'd20,
    OP_EBREAK = 5'd21
  } exu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_WRESP,
    ST_RDATA
  } axil_state_e;

  typedef enum logic [1:0] {
    LS_BYTE,
    LS_HALF,
    LS_WORD,
    LS_DOUBLE
  } ls_size_e;

  // register map, byte offsets
  localparam logic [ADDR_W-1:0] REG_OP1       = 7'h00;
  localparam logic [ADDR_W-1:0] REG_OP2       = 7'h08;
  localparam logic [ADDR_W-1:0] REG_PC        = 7'h10;
  localparam logic [ADDR_W-1:0] REG_IMM       = 7'h18;
  localparam logic [ADDR_W-1:0] REG_CMD       = 7'h20;
  localparam logic [ADDR_W-1:0] REG_RESULT    = 7'h28;
  localparam logic [ADDR_W-1:0] REG_JUMP_ADDR = 7'h30;
  localparam logic [ADDR_W-1:0] REG_STATUS    = 7'h38;
  localparam logic [ADDR_W-1:0] REG_STORE     = 7'h40;
  localparam logic [ADDR_W-1:0] REG_RETIRED   = 7'h48;
  localparam logic [ADDR_W-1:0] REG_TAKEN     = 7'h50;

  // cmd word layout
  localparam int OP_W          = 5;
  localparam int RD_W          = 5;
  localparam int CMD_W         = 14;
  localparam int CMD_OP_LSB    = 0;
  localparam int CMD_WOP_BIT   = 5;
  localparam int CMD_SIZE_LSB  = 6;
  localparam int CMD_USIGN_BIT = 8;
  localparam int CMD_RD_LSB    = 9;

  // status word layout
  localparam int LS_INFO_W   = 7;
  localparam int ST_JUMP_BIT = 0;
  localparam int ST_LS_LSB   = 1;
  localparam int ST_WE_BIT   = 8;
  localparam int ST_RD_LSB   = 9;
  localparam int ST_HALT_BIT = 14;

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

//--- rtl/exu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module exu_regs #(
  parameter int XLEN  = exu_pkg::XLEN,
  parameter int CNT_W = exu_pkg::CNT_W
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          wr_en_i,
  input  logic                          rd_en_i,
  input  logic                          exec_i,
  input  logic [exu_pkg::ADDR_W-1:0]    awaddr_i,
  input  logic [XLEN-1:0]               wdata_i,
  input  logic [exu_pkg::ADDR_W-1:0]    araddr_i,
  input  logic [CNT_W-1:0]              retired_i,
  input  logic [CNT_W-1:0]              taken_i,
  input  logic [XLEN-1:0]               alu_res_i,
  input  logic                          jump_flag_i,
  input  logic [XLEN-1:0]               jump_addr_i,
  input  logic [exu_pkg::LS_INFO_W-1:0] ls_info_i,
  input  logic [XLEN-1:0]               store_data_i,
  output logic                          cmd_ok_o,
  output logic [XLEN-1:0]               rdata_o,
  output logic [1:0]                    rresp_o,
  output logic [XLEN-1:0]               op1_o,
  output logic [XLEN-1:0]               op2_o,
  output logic [XLEN-1:0]               pc_o,
  output logic [XLEN-1:0]               imm_o,
  output exu_pkg::exu_op_e              op_o,
  output logic                          wop_o,
  output exu_pkg::ls_size_e             size_o,
  output logic                          usign_o
);
  import exu_pkg::*;

  logic [CMD_W-1:0]       cmd_q;
  logic [XLEN-1:0]        result_q;
  logic [XLEN-1:0]        jump_q;
  logic [XLEN-1:0]        store_q;
  logic [ST_HALT_BIT-1:0] status_q;
  logic [ST_HALT_BIT-1:0] status_d;
  logic                   halted_q;
  logic                   rd_we;
  logic [XLEN-1:0]        rd_mux;

  // command fields
  assign op_o    = exu_op_e'(cmd_q[CMD_OP_LSB +: OP_W]);
  assign wop_o   = cmd_q[CMD_WOP_BIT];
  assign size_o  = ls_size_e'(cmd_q[CMD_SIZE_LSB +: 2]);
  assign usign_o = cmd_q[CMD_USIGN_BIT];

  assign cmd_ok_o = (cmd_q[CMD_OP_LSB +: OP_W] <= OP_EBREAK) && !halted_q;
  assign rresp_o  = RESP_OKAY;

  // branches, store and ebreak leave rd alone
  assign rd_we = !(op_o inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                                OP_STORE, OP_EBREAK});

  always_comb begin
    status_d = '0;
    status_d[ST_JUMP_BIT] = jump_flag_i;
    status_d[ST_LS_LSB +: LS_INFO_W] = ls_info_i;
    status_d[ST_WE_BIT] = rd_we;
    status_d[ST_RD_LSB +: RD_W] = cmd_q[CMD_RD_LSB +: RD_W];
  end

  // host writes, read-only and unmapped offsets fall through
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      op1_o <= '0;
      op2_o <= '0;
      pc_o  <= '0;
      imm_o <= '0;
      cmd_q <= '0;
    end else if (wr_en_i) begin
      case (awaddr_i)
        REG_OP1: op1_o <= wdata_i;
        REG_OP2: op2_o <= wdata_i;
        REG_PC:  pc_o  <= wdata_i;
        REG_IMM: imm_o <= wdata_i;
        REG_CMD: cmd_q <= wdata_i[CMD_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      result_q <= '0;
      jump_q   <= '0;
      store_q  <= '0;
      status_q <= '0;
      halted_q <= 1'b0;
    end else if (exec_i && cmd_ok_o) begin
      result_q <= alu_res_i;
      jump_q   <= jump_addr_i;
      store_q  <= store_data_i;
      status_q <= status_d;
      // sticky until reset
      if (op_o == OP_EBREAK) begin
        halted_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (araddr_i)
      REG_OP1:       rd_mux = op1_o;
      REG_OP2:       rd_mux = op2_o;
      REG_PC:        rd_mux = pc_o;
      REG_IMM:       rd_mux = imm_o;
      REG_CMD:       rd_mux = XLEN'(cmd_q);
      REG_RESULT:    rd_mux = result_q;
      REG_JUMP_ADDR: rd_mux = jump_q;
      REG_STATUS:    rd_mux = XLEN'({halted_q, status_q});
      REG_STORE:     rd_mux = store_q;
      REG_RETIRED:   rd_mux = XLEN'(retired_i);
      REG_TAKEN:     rd_mux = XLEN'(taken_i);
      default:       rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (rd_en_i) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- rtl/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top #(
  parameter int XLEN  = exu_pkg::XLEN,
  parameter int CNT_W = exu_pkg::CNT_W
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [exu_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [XLEN-1:0]            wdata_i,
  input  logic [XLEN/8-1:0]          wstrb_i,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  output logic [1:0]                 bresp_o,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  input  logic [exu_pkg::ADDR_W-1:0] araddr_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [XLEN-1:0]            rdata_o,
  output logic [1:0]                 rresp_o
);
  import exu_pkg::*;

  logic                 wr_en;
  logic                 rd_en;
  logic                 exec;
  logic                 cmd_ok;
  logic [XLEN-1:0]      op1;
  logic [XLEN-1:0]      op2;
  logic [XLEN-1:0]      pc;
  logic [XLEN-1:0]      imm;
  exu_op_e              op;
  logic                 wop;
  ls_size_e             size;
  logic                 usign;
  logic [XLEN-1:0]      alu_res;
  logic                 jump_flag;
  logic [XLEN-1:0]      jump_addr;
  logic [LS_INFO_W-1:0] ls_info;
  logic [XLEN-1:0]      store_data;
  logic [CNT_W-1:0]     retired;
  logic [CNT_W-1:0]     taken;

  axil_ctrl_fsm u_fsm (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .awvalid_i (awvalid_i),
    .wvalid_i  (wvalid_i),
    .bready_i  (bready_i),
    .arvalid_i (arvalid_i),
    .rready_i  (rready_i),
    .awaddr_i  (awaddr_i),
    .cmd_ok_i  (cmd_ok),
    .awready_o (awready_o),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bresp_o   (bresp_o),
    .arready_o (arready_o),
    .rvalid_o  (rvalid_o),
    .wr_en_o   (wr_en),
    .rd_en_o   (rd_en),
    .exec_o    (exec)
  );

  exu_regs #(
    .XLEN  (XLEN),
    .CNT_W (CNT_W)
  ) u_regs (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .wr_en_i      (wr_en),
    .rd_en_i      (rd_en),
    .exec_i       (exec),
    .awaddr_i     (awaddr_i),
    .wdata_i      (wdata_i),
    .araddr_i     (araddr_i),
    .retired_i    (retired),
    .taken_i      (taken),
    .alu_res_i    (alu_res),
    .jump_flag_i  (jump_flag),
    .jump_addr_i  (jump_addr),
    .ls_info_i    (ls_info),
    .store_data_i (store_data),
    .cmd_ok_o     (cmd_ok),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .op1_o        (op1),
    .op2_o        (op2),
    .pc_o         (pc),
    .imm_o        (imm),
    .op_o         (op),
    .wop_o        (wop),
    .size_o       (size),
    .usign_o      (usign)
  );

  exu_alu #(
    .XLEN (XLEN)
  ) u_alu (
    .op_i         (op),
    .wop_i        (wop),
    .size_i       (size),
    .usign_i      (usign),
    .op1_i        (op1),
    .op2_i        (op2),
    .pc_i         (pc),
    .imm_i        (imm),
    .alu_res_o    (alu_res),
    .jump_flag_o  (jump_flag),
    .jump_addr_o  (jump_addr),
    .ls_info_o    (ls_info),
    .store_data_o (store_data)
  );

  retire_counter #(
    .CNT_W (CNT_W)
  ) u_cnt (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .exec_i      (exec),
    .cmd_ok_i    (cmd_ok),
    .jump_flag_i (jump_flag),
    .retired_o   (retired),
    .taken_o     (taken)
  );

endmodule

`default_nettype wire

//--- rtl/retire_counter.sv
`timescale 1ns/1ps
`default_nettype none

module retire_counter #(
  parameter int CNT_W = exu_pkg::CNT_W
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             exec_i,
  input  logic             cmd_ok_i,
  input  logic             jump_flag_i,
  output logic [CNT_W-1:0] retired_o,
  output logic [CNT_W-1:0] taken_o
);

  // both counts wrap naturally
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      retired_o <= '0;
      taken_o   <= '0;
    end else if (exec_i && cmd_ok_i) begin
      retired_o <= retired_o + 1'b1;
      if (jump_flag_i) begin
        taken_o <= taken_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/exu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exu_checker (
  input logic       clk,
  input logic       rst_n_i,
  input logic       bvalid_i,
  input logic       bready_i,
  input logic [1:0] bresp_i,
  input logic       rvalid_i,
  input logic       rready_i
);

  // a write response waits for bready with a steady code
  b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("bvalid or bresp changed before bready");

  r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  // idle cycle between one response and the next
  one_resp: assert property (@(posedge clk) disable iff (!rst_n_i)
    ((bvalid_i && bready_i) || (rvalid_i && rready_i)) |=> !bvalid_i && !rvalid_i)
    else $error("response valid raised straight after a response handshake");

  reset_quiet: assert property (@(posedge clk)
    !rst_n_i |=> !bvalid_i && !rvalid_i)
    else $error("response valid raised during reset");

endmodule

bind axil_ctrl_fsm exu_checker u_checker (
  .clk      (clk),
  .rst_n_i  (rst_n_i),
  .bvalid_i (bvalid_o),
  .bready_i (bready_i),
  .bresp_i  (bresp_o),
  .rvalid_i (rvalid_o),
  .rready_i (rready_i)
);

`default_nettype wire

//--- tb/exu_trace.hex
// op1 op2 pc imm cmd | expected result jump_addr status store_data bresp
// one operation per line, all values hex
7fffffffffffffff 1 0 0 200 8000000000000000 0 300 0 0
8000000000000000 1 0 0 401 7fffffffffffffff 0 500 0 0
7fffffff 1 0 0 620 ffffffff80000000 0 700 0 0
0 1 0 0 821 ffffffffffffffff 0 900 0 0
8000000000000000 0 0 0 a05 1 0 b00 0 0
8000000000000000 0 0 0 c06 0 0 d00 0 0
1 3f 0 0 e02 8000000000000000 0 f00 0 0
8000000000000000 40 0 0 1003 8000000000000000 0 1100 0 0
8000000000000000 3f 0 0 1204 ffffffffffffffff 0 1300 0 0
ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 1407 f0f0f0f0f0f0f0f0 0 1500 0 0
ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 1408 fff0fff0fff0fff0 0 1500 0 0
ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 1409 0f000f000f000f00 0 1500 0 0
0 12345000 0 0 160a 12345000 0 1700 0 0
0 0 1000 20 20b 1004 1020 301 0 0
2001 0 3000 4 20c 3004 2004 301 0 0
5 5 4000 10 d 0 4010 1 0 0
5 6 4000 10 d 0 4010 0 0 0
5 6 4000 10 e 0 4010 1 0 0
5 5 4000 10 e 0 4010 0 0 0
ffffffffffffffff 1 4000 10 f 0 4010 1 0 0
1 ffffffffffffffff 4000 10 f 0 4010 0 0 0
1 ffffffffffffffff 4000 10 10 0 4010 1 0 0
ffffffffffffffff 1 4000 10 10 0 4010 0 0 0
1 ffffffffffffffff 4000 10 11 0 4010 1 0 0
ffffffffffffffff 1 4000 10 11 0 4010 0 0 0
ffffffffffffffff 1 4000 10 12 0 4010 1 0 0
1 ffffffffffffffff 4000 10 12 0 4010 0 0 0
8000 abcd 0 fffffffffffffff8 1993 7ff8 fffffffffffffff8 194a 0 0
100 55 0 1 1a13 101 1 1b12 0 0
9000 1122334455667788 0 10 d4 9010 10 84 1122334455667788 0
0 0 0 0 16 0 0 0 0 2
0 0 0 0 15 0 0 4000 0 0
1 2 0 0 200 0 0 0 0 2

//--- tb/tb_exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top;
  import exu_pkg::*;

  localparam int OP_WORDS     = 10;
  localparam int MAX_OPS      = 64;
  localparam int MEM_WORDS    = MAX_OPS * OP_WORDS;
  localparam int CLK_HALF     = 5;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY  = 1;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              awvalid;
  logic              awready;
  logic [ADDR_W-1:0] awaddr;
  logic              wvalid;
  logic              wready;
  logic [XLEN-1:0]   wdata;
  logic [XLEN/8-1:0] wstrb;
  logic              bvalid;
  logic              bready;
  logic [1:0]        bresp;
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;
  logic              rvalid;
  logic              rready;
  logic [XLEN-1:0]   rdata;
  logic [1:0]        rresp;

  // ten words per operation, see the header of the trace file
  logic [XLEN-1:0] trace_mem [0:MEM_WORDS-1];

  int num_ops;
  int accepted_cnt;
  int taken_cnt;
  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int seed;

  exu_top #(
    .XLEN  (XLEN),
    .CNT_W (CNT_W)
  ) uut (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  always #CLK_HALF clk = ~clk;

  task automatic end_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
      end_with_failure();
    end
  end

  task automatic check_eq(input string name, input logic [XLEN-1:0] expected,
                          input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end_with_failure();
    end
  endtask

  // inputs change just after the rising edge
  task automatic next_drive_slot();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] data,
                            output logic [1:0] resp);
    logic done;
    int   stall;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = awready && wready;
      next_drive_slot();
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = bvalid;
    end
    next_drive_slot();
    // back-pressure on the write response
    stall = $random(seed) & 3;
    repeat (stall) next_drive_slot();
    bready = 1'b1;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = bvalid && bready;
      resp = bresp;
      next_drive_slot();
    end
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [XLEN-1:0] data);
    logic done;
    int   stall;
    araddr  = addr;
    arvalid = 1'b1;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = arready;
      next_drive_slot();
    end
    arvalid = 1'b0;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = rvalid;
    end
    next_drive_slot();
    stall = $random(seed) & 3;
    repeat (stall) next_drive_slot();
    rready = 1'b1;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = rvalid && rready;
      data = rdata;
      check_eq("rresp", XLEN'(RESP_OKAY), XLEN'(rresp));
      next_drive_slot();
    end
    rready = 1'b0;
  endtask

  task automatic read_expect(input logic [ADDR_W-1:0] addr, input string name,
                             input logic [XLEN-1:0] expected);
    logic [XLEN-1:0] value;
    axil_read(addr, value);
    check_eq(name, expected, value);
  endtask

  task automatic write_expect_okay(input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_eq("bresp", XLEN'(RESP_OKAY), XLEN'(resp));
  endtask

  task automatic run_op(input int idx);
    int         base;
    logic [1:0] resp;
    base = idx * OP_WORDS;
    write_expect_okay(REG_OP1, trace_mem[base]);
    write_expect_okay(REG_OP2, trace_mem[base + 1]);
    write_expect_okay(REG_PC, trace_mem[base + 2]);
    write_expect_okay(REG_IMM, trace_mem[base + 3]);
    axil_write(REG_CMD, trace_mem[base + 4], resp);
    check_eq($sformatf("op %0d bresp", idx), trace_mem[base + 9], XLEN'(resp));
    if (trace_mem[base + 9] == XLEN'(RESP_OKAY)) begin
      accepted_cnt++;
      if (trace_mem[base + 7][ST_JUMP_BIT]) begin
        taken_cnt++;
      end
      read_expect(REG_RESULT, $sformatf("op %0d result", idx), trace_mem[base + 5]);
      read_expect(REG_JUMP_ADDR, $sformatf("op %0d jump_addr", idx), trace_mem[base + 6]);
      read_expect(REG_STATUS, $sformatf("op %0d status", idx), trace_mem[base + 7]);
      read_expect(REG_STORE, $sformatf("op %0d store_data", idx), trace_mem[base + 8]);
    end else begin
      // refused command must not retire
      read_expect(REG_RETIRED, $sformatf("op %0d retired", idx), XLEN'(accepted_cnt));
    end
  endtask

  initial begin
    seed         = 32'h473e;
    rst_n        = 1'b0;
    awvalid      = 1'b0;
    awaddr       = '0;
    wvalid       = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    bready       = 1'b0;
    arvalid      = 1'b0;
    araddr       = '0;
    rready       = 1'b0;
    accepted_cnt = 0;
    taken_cnt    = 0;

    // unused words hold the inverse of their address, marking the trace end
    for (int i = 0; i < MEM_WORDS; i++) begin
      trace_mem[i] = ~XLEN'(i);
    end
    $readmemh("tb/exu_trace.hex", trace_mem);
    num_ops = 0;
    while (num_ops < MAX_OPS &&
           trace_mem[num_ops * OP_WORDS + 4] != ~XLEN'(num_ops * OP_WORDS + 4)) begin
      num_ops++;
    end
    if (num_ops == 0) begin
      $display("the trace file holds no operations");
      end_with_failure();
    end
    cycle_limit = num_ops * 80 + 200;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    @(negedge clk);
    check_eq("bvalid after reset", '0, XLEN'(bvalid));
    check_eq("rvalid after reset", '0, XLEN'(rvalid));
    next_drive_slot();
    read_expect(REG_RESULT, "result after reset", '0);
    read_expect(REG_STATUS, "status after reset", '0);
    read_expect(REG_RETIRED, "retired after reset", '0);
    read_expect(REG_TAKEN, "taken after reset", '0);

    for (int i = 0; i < num_ops; i++) begin
      run_op(i);
    end

    read_expect(REG_RETIRED, "final retired", XLEN'(accepted_cnt));
    read_expect(REG_TAKEN, "final taken", XLEN'(taken_cnt));

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
